//--- project.f
tm_if_pkg.sv
sync_fifo.sv
tm_if_ctrl.sv
rc_counter.sv
copy_pipeline.sv
release_mux.sv
tm_if_top.sv
tb_clk_gen.sv
tb_tm_if.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_tm_if -f project.f -o sim_tm_if

./obj_dir/sim_tm_if | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

//--- tb_tm_if.sv
/*
 * directed tests for the replication to TM interface
 * TM responder, output monitor, checks and watchdog
 */
`default_nettype none

module tb_tm_if
	import tm_if_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS     = 4;
	localparam int POLL_WAIT  = 150;   // cycles to cover the clear sweep
	localparam int DRAIN_WAIT = 200;
	localparam int SETTLE     = 12;

	// worst case per test in cycles
	localparam int T_SWEEP = 400;
	localparam int T_UCAST = 400;
	localparam int T_MCAST = 900;
	localparam int T_DROP  = 600;
	localparam int T_DISC  = 400;
	localparam int T_BP    = 1600;
	localparam int WATCHDOG_CYC = T_SWEEP + T_UCAST + T_MCAST + T_DROP + T_DISC + T_BP + 1000;

	typedef struct packed {
		logic [QID_W-1:0]     qid;
		logic [CONN_W-1:0]    conn_id;
		logic [GROUP_W-1:0]   group_id;
		logic [PQ_W-1:0]      pq_id;
		logic [PORT_W-1:0]    src_port;
		logic [PORT_W-1:0]    dst_port;
		logic [BUF_PTR_W-1:0] buf_ptr;
		logic [PKT_LEN_W-1:0] packet_length;
	} enq_rec_t;

	typedef struct packed {
		logic [QID_W-1:0]  qid;
		logic [PORT_W-1:0] src_port;
	} poll_rec_t;

	logic clk, rst_n;
	logic rep_req, rep_drop, rep_ucast, rep_last;
	logic [PKT_ID_W-1:0] rep_packet_id;
	logic [QID_W-1:0] rep_qid;
	logic [PORT_W-1:0] rep_src_port;
	logic [BUF_PTR_W-1:0] rep_buf_ptr;
	logic [PKT_LEN_W-1:0] rep_packet_length;
	logic tm_poll_ack, tm_poll_drop;
	logic [CONN_W-1:0] tm_poll_conn_id;
	logic [GROUP_W-1:0] tm_poll_group_id;
	logic [PQ_W-1:0] tm_poll_port_queue_id;
	logic [PORT_W-1:0] tm_poll_port_id;
	logic discard_req;
	logic [PORT_W-1:0] discard_src_port;
	logic [BUF_PTR_W-1:0] discard_buf_ptr;
	logic [PKT_LEN_W-1:0] discard_packet_length;
	logic rep_bp, tm_poll_req, tm_enq_req, bm_release_valid;
	logic [QID_W-1:0] tm_poll_qid, tm_enq_qid;
	logic [PORT_W-1:0] tm_poll_src_port, tm_enq_src_port, tm_enq_dst_port, bm_src_port;
	logic [CONN_W-1:0] tm_enq_conn_id;
	logic [GROUP_W-1:0] tm_enq_group_id;
	logic [PQ_W-1:0] tm_enq_port_queue_id;
	logic [BUF_PTR_W-1:0] tm_enq_buf_ptr, bm_buf_ptr;
	logic [PKT_LEN_W-1:0] tm_enq_packet_length, bm_packet_length;
	logic [RC_W-1:0] bm_read_count;

	copy_t     sent_q [$];   // pushed but not yet acked
	poll_rec_t got_poll_q [$];
	int        got_poll_cyc [$];
	enq_rec_t  exp_enq_q [$];
	enq_rec_t  got_enq_q [$];
	int        got_enq_cyc [$];
	release_t  exp_rel_q [$];
	release_t  got_rel_q [$];
	int        got_rel_cyc [$];
	int        read_cnt [2 ** PKT_ID_W] = '{default: 0};   // count model per packet
	int        cyc = 0;
	int        last_ack_cyc;
	string     test_name;
	int        test_err;
	int        total_err = 0;
	int        tests_run = 0;
	int        tests_failed = 0;

	tb_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(8)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	tm_if_top u_tm_if_top (.*);

	// ******************** monitor
	always @(posedge clk)
		cyc <= cyc + 1;

	always @(negedge clk) begin
		if (rst_n) begin
			if (tm_poll_req) begin
				got_poll_q.push_back(poll_rec_t'{qid: tm_poll_qid, src_port: tm_poll_src_port});
				got_poll_cyc.push_back(cyc);
			end
			if (tm_enq_req) begin
				got_enq_q.push_back(enq_rec_t'{qid: tm_enq_qid, conn_id: tm_enq_conn_id,
					group_id: tm_enq_group_id, pq_id: tm_enq_port_queue_id,
					src_port: tm_enq_src_port, dst_port: tm_enq_dst_port,
					buf_ptr: tm_enq_buf_ptr, packet_length: tm_enq_packet_length});
				got_enq_cyc.push_back(cyc);
			end
			if (bm_release_valid) begin
				got_rel_q.push_back(release_t'{read_count: bm_read_count,
					src_port: bm_src_port, buf_ptr: bm_buf_ptr,
					packet_length: bm_packet_length});
				got_rel_cyc.push_back(cyc);
			end
		end
	end

	// ******************** helpers
	task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] got);
		assert (exp == got) else begin
			$display("** Error %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, got);
			test_err++;
		end
	endtask

	task automatic require_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("%s failed: %s", test_name, msg);
			test_err++;
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_err  = 0;
	endtask

	task automatic close_test();
		tests_run++;
		total_err += test_err;
		if (test_err == 0) begin
			$display("%s: passed", test_name);
		end else begin
			$display("%s: %0d errors", test_name, test_err);
			tests_failed++;
		end
	endtask

	task automatic push_copy(input logic is_ucast, input logic is_last, input logic is_drop,
			input logic [PKT_ID_W-1:0] pid);
		copy_t c;
		c = copy_t'{ucast: is_ucast, last: is_last, drop: is_drop, packet_id: pid,
			qid: QID_W'($urandom), src_port: PORT_W'($urandom),
			buf_ptr: BUF_PTR_W'($urandom), packet_length: PKT_LEN_W'($urandom)};
		@(negedge clk);
		rep_req           = 1'b1;
		rep_ucast         = c.ucast;
		rep_last          = c.last;
		rep_drop          = c.drop;
		rep_packet_id     = c.packet_id;
		rep_qid           = c.qid;
		rep_src_port      = c.src_port;
		rep_buf_ptr       = c.buf_ptr;
		rep_packet_length = c.packet_length;
		sent_q.push_back(c);
		@(negedge clk);
		rep_req = 1'b0;
	endtask

	task automatic await_polls(input int n, output logic ok);
		int waited;
		waited = 0;
		while (got_poll_q.size() < n && waited < POLL_WAIT) begin
			@(negedge clk);
			waited++;
		end
		ok = (got_poll_q.size() >= n);
		require_true(ok, $sformatf("no %0d polls within %0d cycles", n, POLL_WAIT));
	endtask

	// TM side acks each poll on consecutive cycles
	task automatic ack_polls(input int n, input logic [31:0] tm_drop);
		copy_t     c;
		poll_rec_t p;
		logic      ok;
		await_polls(n, ok);
		if (!ok)
			return;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			c = sent_q.pop_front();
			p = got_poll_q.pop_front();
			void'(got_poll_cyc.pop_front());
			check_val("poll qid", c.qid, p.qid);
			check_val("poll src_port", c.src_port, p.src_port);
			tm_poll_ack           = 1'b1;
			tm_poll_drop          = tm_drop[i];
			tm_poll_conn_id       = CONN_W'($urandom);
			tm_poll_group_id      = GROUP_W'($urandom);
			tm_poll_port_queue_id = PQ_W'($urandom);
			tm_poll_port_id       = PORT_W'($urandom);
			last_ack_cyc          = cyc;
			if (!(tm_drop[i] || c.drop)) begin   // copy survives
				exp_enq_q.push_back(enq_rec_t'{qid: c.qid, conn_id: tm_poll_conn_id,
					group_id: tm_poll_group_id, pq_id: tm_poll_port_queue_id,
					src_port: c.src_port, dst_port: tm_poll_port_id,
					buf_ptr: c.buf_ptr, packet_length: c.packet_length});
				read_cnt[c.packet_id]++;
			end
			if (c.ucast || c.last) begin
				exp_rel_q.push_back(release_t'{read_count: RC_W'(read_cnt[c.packet_id]),
					src_port: c.src_port, buf_ptr: c.buf_ptr,
					packet_length: c.packet_length});
				read_cnt[c.packet_id] = 0;
			end
		end
		@(negedge clk);
		tm_poll_ack  = 1'b0;
		tm_poll_drop = 1'b0;
	endtask

	task automatic drain_outputs();
		int waited;
		waited = 0;
		while ((got_enq_q.size() < exp_enq_q.size() || got_rel_q.size() < exp_rel_q.size())
				&& waited < DRAIN_WAIT) begin
			@(negedge clk);
			waited++;
		end
		require_true(waited < DRAIN_WAIT, "expected enqueues or releases never arrived");
		repeat (SETTLE) @(negedge clk);   // catches extra outputs
	endtask

	task automatic compare_outputs();
		check_val("enqueue count", exp_enq_q.size(), got_enq_q.size());
		check_val("release count", exp_rel_q.size(), got_rel_q.size());
		while (exp_enq_q.size() > 0 && got_enq_q.size() > 0)
			check_val("enqueue record", exp_enq_q.pop_front(), got_enq_q.pop_front());
		while (exp_rel_q.size() > 0 && got_rel_q.size() > 0)
			check_val("release record", exp_rel_q.pop_front(), got_rel_q.pop_front());
		exp_enq_q.delete();
		got_enq_q.delete();
		got_enq_cyc.delete();
		exp_rel_q.delete();
		got_rel_q.delete();
		got_rel_cyc.delete();
	endtask

	// ******************** tests
	task automatic reset_and_sweep();
		int   rst_cyc;
		logic ok;
		open_test("reset_sweep");
		wait (rst_n === 1'b1);
		rst_cyc = cyc;
		@(negedge clk);
		check_val("rep_bp after reset", 0, rep_bp);
		check_val("tm_poll_req after reset", 0, tm_poll_req);
		check_val("tm_enq_req after reset", 0, tm_enq_req);
		check_val("bm_release_valid after reset", 0, bm_release_valid);
		push_copy(1'b1, 1'b0, 1'b0, PKT_ID_W'(5));
		await_polls(1, ok);
		if (ok)
			require_true(got_poll_cyc[0] - rst_cyc >= 2 ** PKT_ID_W,
				"poll issued before the clear sweep ended");
		ack_polls(1, 0);
		drain_outputs();
		compare_outputs();
		close_test();
	endtask

	task automatic single_unicast();
		int ack_cyc;
		open_test("single_unicast");
		push_copy(1'b1, 1'b0, 1'b0, PKT_ID_W'(9));
		ack_polls(1, 0);
		ack_cyc = last_ack_cyc;
		drain_outputs();
		if (got_enq_cyc.size() > 0)
			check_val("enqueue cycle", ack_cyc + 3, got_enq_cyc[0]);
		if (got_rel_q.size() > 0)
			check_val("release read count", 1, got_rel_q[0].read_count);
		compare_outputs();
		close_test();
	endtask

	task automatic multicast_back_to_back();
		open_test("multicast_b2b");
		for (int i = 0; i < 4; i++)
			push_copy(1'b0, i == 3, 1'b0, PKT_ID_W'(17));
		ack_polls(4, 32'b0010);   // TM drops the second copy
		drain_outputs();
		check_val("enqueue count", 3, got_enq_q.size());
		if (got_rel_q.size() > 0)
			check_val("release read count", 3, got_rel_q[0].read_count);
		compare_outputs();
		push_copy(1'b1, 1'b0, 1'b0, PKT_ID_W'(17));   // same id again
		ack_polls(1, 0);
		drain_outputs();
		if (got_rel_q.size() > 0)
			check_val("read count after restart", 1, got_rel_q[0].read_count);
		compare_outputs();
		close_test();
	endtask

	task automatic all_copies_dropped();
		open_test("all_dropped");
		push_copy(1'b0, 1'b0, 1'b1, PKT_ID_W'(33));
		push_copy(1'b0, 1'b0, 1'b0, PKT_ID_W'(33));
		push_copy(1'b0, 1'b1, 1'b1, PKT_ID_W'(33));
		ack_polls(3, 32'b010);
		drain_outputs();
		check_val("enqueue count", 0, got_enq_q.size());
		if (got_rel_q.size() > 0)
			check_val("release read count", 0, got_rel_q[0].read_count);
		compare_outputs();
		close_test();
	endtask

	task automatic discard_priority();
		int disc_cyc;
		open_test("discard_priority");
		push_copy(1'b1, 1'b0, 1'b0, PKT_ID_W'(40));
		ack_polls(1, 0);
		// the release is pushed as this discard is sampled
		while (cyc < last_ack_cyc + 3)
			@(negedge clk);
		discard_req           = 1'b1;
		discard_src_port      = PORT_W'($urandom);
		discard_buf_ptr       = BUF_PTR_W'($urandom);
		discard_packet_length = PKT_LEN_W'($urandom);
		disc_cyc              = cyc;
		exp_rel_q.push_front(release_t'{read_count: '0, src_port: discard_src_port,
			buf_ptr: discard_buf_ptr, packet_length: discard_packet_length});
		@(negedge clk);
		discard_req = 1'b0;
		drain_outputs();
		if (got_rel_cyc.size() > 0)
			check_val("discard output cycle", disc_cyc + 2, got_rel_cyc[0]);
		compare_outputs();
		close_test();
	endtask

	task automatic back_pressure();
		int pushed;
		open_test("back_pressure");
		pushed = 0;
		while (!rep_bp && pushed < 2 ** PKT_ID_W) begin   // acks held off
			push_copy(1'b1, 1'b0, 1'b0, PKT_ID_W'(pushed));
			pushed++;
			@(negedge clk);   // rep_bp lags the intake count by one cycle
		end
		require_true(rep_bp, "rep_bp never rose with acks held");
		check_val("polls while acks held", 2 ** PEND_DEPTH_W, got_poll_q.size());
		require_true(pushed - got_poll_q.size() > BP_ON,
			"rep_bp rose before the intake passed its upper threshold");
		for (int i = 0; i < pushed && sent_q.size() > 0; i++)
			ack_polls(1, 0);
		require_true(!rep_bp, "rep_bp still high after the held copies drained");
		drain_outputs();
		compare_outputs();
		close_test();
	endtask

	// ******************** main
	initial begin
		void'($urandom(44));
		rep_req               = 1'b0;
		rep_drop              = 1'b0;
		rep_ucast             = 1'b0;
		rep_last              = 1'b0;
		rep_packet_id         = '0;
		rep_qid               = '0;
		rep_src_port          = '0;
		rep_buf_ptr           = '0;
		rep_packet_length     = '0;
		tm_poll_ack           = 1'b0;
		tm_poll_drop          = 1'b0;
		tm_poll_conn_id       = '0;
		tm_poll_group_id      = '0;
		tm_poll_port_queue_id = '0;
		tm_poll_port_id       = '0;
		discard_req           = 1'b0;
		discard_src_port      = '0;
		discard_buf_ptr       = '0;
		discard_packet_length = '0;
		reset_and_sweep();
		single_unicast();
		multicast_back_to_back();
		all_copies_dropped();
		discard_priority();
		back_pressure();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total_err);
		if (total_err == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_NS);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
/*
 * testbench clock and power-on reset
 */
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);   // released away from the rising edge
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- tm_if_top.sv
/*
 * replication to traffic manager interface, top level
 */
`default_nettype none

module tm_if_top
	import tm_if_pkg::*;
#(
	parameter int PKT_ID_W = tm_if_pkg::PKT_ID_W
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rep_req,
	input  logic                 rep_drop,
	input  logic                 rep_ucast,
	input  logic                 rep_last,
	input  logic [PKT_ID_W-1:0]  rep_packet_id,
	input  logic [QID_W-1:0]     rep_qid,
	input  logic [PORT_W-1:0]    rep_src_port,
	input  logic [BUF_PTR_W-1:0] rep_buf_ptr,
	input  logic [PKT_LEN_W-1:0] rep_packet_length,
	input  logic                 tm_poll_ack,
	input  logic                 tm_poll_drop,
	input  logic [CONN_W-1:0]    tm_poll_conn_id,
	input  logic [GROUP_W-1:0]   tm_poll_group_id,
	input  logic [PQ_W-1:0]      tm_poll_port_queue_id,
	input  logic [PORT_W-1:0]    tm_poll_port_id,
	input  logic                 discard_req,
	input  logic [PORT_W-1:0]    discard_src_port,
	input  logic [BUF_PTR_W-1:0] discard_buf_ptr,
	input  logic [PKT_LEN_W-1:0] discard_packet_length,
	output logic                 rep_bp,
	output logic                 tm_poll_req,
	output logic [QID_W-1:0]     tm_poll_qid,
	output logic [PORT_W-1:0]    tm_poll_src_port,
	output logic                 tm_enq_req,
	output logic [QID_W-1:0]     tm_enq_qid,
	output logic [CONN_W-1:0]    tm_enq_conn_id,
	output logic [GROUP_W-1:0]   tm_enq_group_id,
	output logic [PQ_W-1:0]      tm_enq_port_queue_id,
	output logic [PORT_W-1:0]    tm_enq_src_port,
	output logic [PORT_W-1:0]    tm_enq_dst_port,
	output logic [BUF_PTR_W-1:0] tm_enq_buf_ptr,
	output logic [PKT_LEN_W-1:0] tm_enq_packet_length,
	output logic                 bm_release_valid,
	output logic [RC_W-1:0]      bm_read_count,
	output logic [PORT_W-1:0]    bm_src_port,
	output logic [BUF_PTR_W-1:0] bm_buf_ptr,
	output logic [PKT_LEN_W-1:0] bm_packet_length
);

	copy_t                   intake_din;
	copy_t                   intake_dout;
	logic [INTAKE_DEPTH_W:0] intake_count;
	logic                    intake_empty;
	logic                    intake_rd;
	copy_t                   pend_head;
	logic                    pend_wr;
	logic                    pend_rd;
	logic                    pend_full;
	logic                    ack_valid;
	logic                    clear_busy;
	logic [PKT_ID_W-1:0]     clear_addr;
	logic                    lookup_valid;
	logic [PKT_ID_W-1:0]     lookup_id;
	logic                    copy_drop;
	logic                    copy_final;
	logic [RC_W-1:0]         final_count;
	release_t                rel_din;
	release_t                rel_head;
	logic                    rel_wr;
	logic                    rel_rd;
	logic                    rel_empty;

	assign intake_din = '{ucast: rep_ucast, last: rep_last, drop: rep_drop,
		packet_id: rep_packet_id, qid: rep_qid, src_port: rep_src_port,
		buf_ptr: rep_buf_ptr, packet_length: rep_packet_length};

	// ******************** FIFOs
	sync_fifo #(.payload_t(copy_t), .DEPTH_W(INTAKE_DEPTH_W)) u_intake_fifo (
		.clk(clk), .rst_n(rst_n),
		.wr(rep_req), .rd(intake_rd), .din(intake_din), .dout(intake_dout),
		.count(intake_count), .full(), .empty(intake_empty)
	);

	sync_fifo #(.payload_t(copy_t), .DEPTH_W(PEND_DEPTH_W)) u_pend_fifo (
		.clk(clk), .rst_n(rst_n),
		.wr(pend_wr), .rd(pend_rd), .din(intake_dout), .dout(pend_head),
		.count(), .full(pend_full), .empty()
	);

	sync_fifo #(.payload_t(release_t), .DEPTH_W(REL_DEPTH_W)) u_rel_fifo (
		.clk(clk), .rst_n(rst_n),
		.wr(rel_wr), .rd(rel_rd), .din(rel_din), .dout(rel_head),
		.count(), .full(), .empty(rel_empty)
	);

	// ******************** control and datapath
	tm_if_ctrl #(.PKT_ID_W(PKT_ID_W)) u_tm_if_ctrl (
		.intake_head_qid(intake_dout.qid),
		.intake_head_src_port(intake_dout.src_port),
		.*
	);

	rc_counter #(.PKT_ID_W(PKT_ID_W)) u_rc_counter (.*);

	copy_pipeline u_copy_pipeline (.*);

	release_mux u_release_mux (.*);

endmodule

`default_nettype wire

//--- release_mux.sv
/*
 * buffer-manager output, discard wins over queued release
 */
`default_nettype none

module release_mux
	import tm_if_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 discard_req,
	input  logic [PORT_W-1:0]    discard_src_port,
	input  logic [BUF_PTR_W-1:0] discard_buf_ptr,
	input  logic [PKT_LEN_W-1:0] discard_packet_length,
	input  logic                 rel_empty,
	input  release_t             rel_head,
	output logic                 rel_rd,
	output logic                 bm_release_valid,
	output logic [RC_W-1:0]      bm_read_count,
	output logic [PORT_W-1:0]    bm_src_port,
	output logic [BUF_PTR_W-1:0] bm_buf_ptr,
	output logic [PKT_LEN_W-1:0] bm_packet_length
);

	logic                 disc_valid;
	logic [PORT_W-1:0]    disc_src_port;
	logic [BUF_PTR_W-1:0] disc_buf_ptr;
	logic [PKT_LEN_W-1:0] disc_packet_length;

	assign rel_rd = !rel_empty && !disc_valid;   // release waits a cycle

	always_ff @(posedge clk) begin
		disc_src_port      <= discard_src_port;
		disc_buf_ptr       <= discard_buf_ptr;
		disc_packet_length <= discard_packet_length;
		bm_read_count      <= disc_valid ? '0 : rel_head.read_count;
		bm_src_port        <= disc_valid ? disc_src_port : rel_head.src_port;
		bm_buf_ptr         <= disc_valid ? disc_buf_ptr : rel_head.buf_ptr;
		bm_packet_length   <= disc_valid ? disc_packet_length : rel_head.packet_length;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			disc_valid       <= 1'b0;
			bm_release_valid <= 1'b0;
		end else begin
			disc_valid       <= discard_req;
			bm_release_valid <= disc_valid || rel_rd;
		end
	end

	// discards are spaced so queued releases still drain
	a_discard_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		discard_req |=> !discard_req);

endmodule

`default_nettype wire

//--- copy_pipeline.sv
/*
 * ack and copy alignment with the count lookup
 * TM enqueue outputs and release push
 */
`default_nettype none

module copy_pipeline
	import tm_if_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ack_valid,
	input  copy_t                pend_head,
	input  logic                 tm_poll_drop,
	input  logic [CONN_W-1:0]    tm_poll_conn_id,
	input  logic [GROUP_W-1:0]   tm_poll_group_id,
	input  logic [PQ_W-1:0]      tm_poll_port_queue_id,
	input  logic [PORT_W-1:0]    tm_poll_port_id,
	input  logic [RC_W-1:0]      final_count,
	output logic                 tm_enq_req,
	output logic [QID_W-1:0]     tm_enq_qid,
	output logic [CONN_W-1:0]    tm_enq_conn_id,
	output logic [GROUP_W-1:0]   tm_enq_group_id,
	output logic [PQ_W-1:0]      tm_enq_port_queue_id,
	output logic [PORT_W-1:0]    tm_enq_src_port,
	output logic [PORT_W-1:0]    tm_enq_dst_port,
	output logic [BUF_PTR_W-1:0] tm_enq_buf_ptr,
	output logic [PKT_LEN_W-1:0] tm_enq_packet_length,
	output logic                 lookup_valid,
	output logic [PKT_ID_W-1:0]  lookup_id,
	output logic                 copy_drop,
	output logic                 copy_final,
	output logic                 rel_wr,
	output release_t             rel_din
);

	copy_t                s1_copy;
	logic                 s1_tm_drop;
	logic [CONN_W-1:0]    s1_conn_id;
	logic [GROUP_W-1:0]   s1_group_id;
	logic [PQ_W-1:0]      s1_pq_id;
	logic [PORT_W-1:0]    s1_port_id;
	logic                 s2_valid;
	logic                 s2_drop;
	logic                 s2_final;
	copy_t                s2_copy;
	logic [CONN_W-1:0]    s2_conn_id;
	logic [GROUP_W-1:0]   s2_group_id;
	logic [PQ_W-1:0]      s2_pq_id;
	logic [PORT_W-1:0]    s2_port_id;
	logic                 s3_valid;
	logic                 s3_final;

	// ******************** stage 1, lookup
	// head captured in the ack cycle, it is popped there
	assign lookup_valid = ack_valid;
	assign lookup_id    = s1_copy.packet_id;
	assign copy_drop    = s1_tm_drop | s1_copy.drop;
	assign copy_final   = s1_copy.ucast | s1_copy.last;

	// ******************** stage 3, outputs
	assign rel_wr  = s3_valid && s3_final;
	assign rel_din = '{read_count: final_count, src_port: tm_enq_src_port,
		buf_ptr: tm_enq_buf_ptr, packet_length: tm_enq_packet_length};

	always_ff @(posedge clk) begin
		s1_copy     <= pend_head;
		s1_tm_drop  <= tm_poll_drop;
		s1_conn_id  <= tm_poll_conn_id;
		s1_group_id <= tm_poll_group_id;
		s1_pq_id    <= tm_poll_port_queue_id;
		s1_port_id  <= tm_poll_port_id;
		s2_copy     <= s1_copy;
		s2_drop     <= copy_drop;
		s2_final    <= copy_final;
		s2_conn_id  <= s1_conn_id;
		s2_group_id <= s1_group_id;
		s2_pq_id    <= s1_pq_id;
		s2_port_id  <= s1_port_id;
		s3_final    <= s2_final;
		tm_enq_qid           <= s2_copy.qid;
		tm_enq_conn_id       <= s2_conn_id;
		tm_enq_group_id      <= s2_group_id;
		tm_enq_port_queue_id <= s2_pq_id;
		tm_enq_src_port      <= s2_copy.src_port;
		tm_enq_dst_port      <= s2_port_id;   // TM picks the port
		tm_enq_buf_ptr       <= s2_copy.buf_ptr;
		tm_enq_packet_length <= s2_copy.packet_length;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_valid   <= 1'b0;
			s3_valid   <= 1'b0;
			tm_enq_req <= 1'b0;
		end else begin
			s2_valid   <= ack_valid;
			s3_valid   <= s2_valid;
			tm_enq_req <= s2_valid && !s2_drop;
		end
	end

endmodule

`default_nettype wire

//--- rc_counter.sv
/*
 * per-packet read-count table with clear port,
 * read pipeline and forwarding of the two latest writes
 */
`default_nettype none

module rc_counter
	import tm_if_pkg::*;
#(
	parameter int PKT_ID_W = tm_if_pkg::PKT_ID_W
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                clear_busy,
	input  logic [PKT_ID_W-1:0] clear_addr,
	input  logic                lookup_valid,
	input  logic [PKT_ID_W-1:0] lookup_id,
	input  logic                copy_drop,
	input  logic                copy_final,
	output logic [RC_W-1:0]     final_count
);

	logic [RC_W-1:0]     mem [2 ** PKT_ID_W];
	logic [RC_W-1:0]     rd_q;
	logic                s2_valid;
	logic [PKT_ID_W-1:0] s2_id;
	logic                s2_drop;
	logic                s2_final;
	logic [RC_W-1:0]     fwd_count;
	logic                s3_valid;
	logic [PKT_ID_W-1:0] s3_id;
	logic                s3_drop;
	logic                s3_final;
	logic [RC_W-1:0]     s3_count;
	logic                upd_wr;
	logic [RC_W-1:0]     upd_data;
	logic                upd_wr_d;
	logic [PKT_ID_W-1:0] upd_id_d;
	logic [RC_W-1:0]     upd_data_d;

	// ******************** table
	always_ff @(posedge clk) begin
		if (clear_busy)
			mem[clear_addr] <= '0;
		else if (upd_wr)
			mem[s3_id] <= upd_data;
		rd_q <= mem[lookup_id];
	end

	// newest write first, RAM holds the rest
	assign fwd_count = (upd_wr && s3_id == s2_id) ? upd_data :
		(upd_wr_d && upd_id_d == s2_id) ? upd_data_d : rd_q;

	assign final_count = s3_count + {{(RC_W-1){1'b0}}, !s3_drop};
	assign upd_wr      = s3_valid && (s3_final || !s3_drop);
	assign upd_data    = s3_final ? '0 : final_count;   // last copy restarts at 0

	always_ff @(posedge clk) begin
		s2_id      <= lookup_id;
		s2_drop    <= copy_drop;
		s2_final   <= copy_final;
		s3_id      <= s2_id;
		s3_drop    <= s2_drop;
		s3_final   <= s2_final;
		s3_count   <= fwd_count;
		upd_id_d   <= s3_id;
		upd_data_d <= upd_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			upd_wr_d <= 1'b0;
		end else begin
			s2_valid <= lookup_valid;
			s3_valid <= s2_valid;
			upd_wr_d <= upd_wr;
		end
	end

	// polls wait for the sweep, so no ack can reach the table before it ends
	a_lookup_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
		lookup_valid |-> !clear_busy);

endmodule

`default_nettype wire

//--- tm_if_ctrl.sv
/*
 * counter-clear sweep, intake pop and TM poll issue
 * back-pressure hysteresis and pending pop on ack
 */
`default_nettype none

module tm_if_ctrl
	import tm_if_pkg::*;
#(
	parameter int PKT_ID_W = tm_if_pkg::PKT_ID_W
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [INTAKE_DEPTH_W:0] intake_count,
	input  logic                    intake_empty,
	input  logic                    pend_full,
	input  logic                    tm_poll_ack,
	input  logic [QID_W-1:0]        intake_head_qid,
	input  logic [PORT_W-1:0]       intake_head_src_port,
	output logic                    intake_rd,
	output logic                    pend_wr,
	output logic                    pend_rd,
	output logic                    ack_valid,
	output logic                    clear_busy,
	output logic [PKT_ID_W-1:0]     clear_addr,
	output logic                    rep_bp,
	output logic                    tm_poll_req,
	output logic [QID_W-1:0]        tm_poll_qid,
	output logic [PORT_W-1:0]       tm_poll_src_port
);

	typedef enum logic [1:0] {
		SWEEP_IDLE,
		SWEEP_CLEAR,
		SWEEP_DONE
	} sweep_st_t;

	sweep_st_t sweep_st;

	// ******************** clear sweep
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sweep_st   <= SWEEP_IDLE;
			clear_addr <= '0;
		end else begin
			case (sweep_st)
				SWEEP_IDLE: sweep_st <= SWEEP_CLEAR;
				SWEEP_CLEAR: begin
					clear_addr <= clear_addr + 1'b1;
					if (&clear_addr)
						sweep_st <= SWEEP_DONE;   // last entry zeroed
				end
				default: sweep_st <= SWEEP_DONE;
			endcase
		end
	end

	assign clear_busy = (sweep_st == SWEEP_CLEAR);

	// ******************** poll issue
	// copy moves from intake to pending in the pop cycle
	assign intake_rd = !intake_empty && !pend_full && (sweep_st == SWEEP_DONE);
	assign pend_wr   = intake_rd;
	assign pend_rd   = tm_poll_ack;   // acks come in poll order

	always_ff @(posedge clk) begin
		tm_poll_qid      <= intake_head_qid;
		tm_poll_src_port <= intake_head_src_port;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tm_poll_req <= 1'b0;
			ack_valid   <= 1'b0;
			rep_bp      <= 1'b0;
		end else begin
			tm_poll_req <= intake_rd;
			ack_valid   <= tm_poll_ack;
			if (intake_count > BP_ON)
				rep_bp <= 1'b1;
			else if (intake_count < BP_OFF)
				rep_bp <= 1'b0;   // between thresholds hold
		end
	end

endmodule

`default_nettype wire

//--- sync_fifo.sv
/*
 * register-array synchronous FIFO, payload set by type parameter
 */
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH_W   = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr,
	input  logic             rd,
	input  payload_t         din,
	output payload_t         dout,
	output logic [DEPTH_W:0] count,
	output logic             full,
	output logic             empty
);

	localparam int DEPTH = 2 ** DEPTH_W;

	payload_t           mem [DEPTH];
	logic [DEPTH_W-1:0] wptr;
	logic [DEPTH_W-1:0] rptr;

	assign dout  = mem[rptr];   // head
	assign full  = count[DEPTH_W];
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (wr)
			mem[wptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr)
				wptr <= wptr + 1'b1;
			if (rd)
				rptr <= rptr + 1'b1;
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// ******************** usage checks
	a_push_full: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full);
	a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty);

endmodule

`default_nettype wire

//--- tm_if_pkg.sv
/*
 * widths, FIFO depths and back-pressure thresholds
 * copy and release FIFO payload structs
 */
`default_nettype none

package tm_if_pkg;

	// ******************** field widths
	localparam int PORT_W    = 4;
	localparam int QID_W     = 8;    // first-level queue
	localparam int CONN_W    = 10;
	localparam int GROUP_W   = 6;
	localparam int PQ_W      = 4;    // port queue
	localparam int PKT_ID_W  = 6;    // 64 table entries
	localparam int RC_W      = 5;
	localparam int BUF_PTR_W = 12;
	localparam int PKT_LEN_W = 14;

	// ******************** depths and thresholds
	localparam int INTAKE_DEPTH_W = 4;   // 16 entries
	localparam int PEND_DEPTH_W   = 5;   // 32 entries
	localparam int REL_DEPTH_W    = 5;
	localparam int BP_ON          = 10;  // bp rises above this fill
	localparam int BP_OFF         = 6;   // and drops below this one

	// one copy request, intake and pending payload
	typedef struct packed {
		logic                 ucast;
		logic                 last;
		logic                 drop;
		logic [PKT_ID_W-1:0]  packet_id;
		logic [QID_W-1:0]     qid;
		logic [PORT_W-1:0]    src_port;
		logic [BUF_PTR_W-1:0] buf_ptr;
		logic [PKT_LEN_W-1:0] packet_length;
	} copy_t;

	// one buffer release
	typedef struct packed {
		logic [RC_W-1:0]      read_count;
		logic [PORT_W-1:0]    src_port;
		logic [BUF_PTR_W-1:0] buf_ptr;
		logic [PKT_LEN_W-1:0] packet_length;
	} release_t;

endpackage

`default_nettype wire
